/* design/pal_pkg.sv */
// palette widths, colour channel widths and palette entry field positions
`default_nettype none

package pal_pkg;

    // palette address, 4096 words
    localparam int pal_aw = 12;
    // one palette entry
    localparam int pal_dw = 16;

    // output colour channels
    localparam int chan_w = 5;
    // packed as red, green, blue from the top
    localparam int rgb_w = 3 * chan_w;

    // set selects light, clear selects dim
    localparam int shade_bit = 15;

    // low bit of each channel's upper nibble
    localparam int red_nib_lsb = 0;
    localparam int grn_nib_lsb = 4;
    localparam int blu_nib_lsb = 8;

    // extra bit that becomes each channel's lsb
    localparam int red_ext_bit = 12;
    localparam int grn_ext_bit = 13;
    localparam int blu_ext_bit = 14;

endpackage

`default_nettype wire

/* design/layer_pkg.sv */
// layer input widths, object pixel fields and road palette bank prefix
`default_nettype none

package layer_pkg;

    // tile map generator output
    localparam int tmap_w = 11;
    // sprite pixel
    localparam int obj_w = 14;
    // road pixel
    localparam int road_w = 8;

    // road entries live in the 0x400 quarter of the palette
    localparam logic [1:0] road_bank = 2'b01;

    // object colour nibble, bits 3..0
    localparam int obj_col_w = 4;
    // palette group, bits 11..10
    localparam int obj_grp_lsb = 10;
    // palette bank, bits 13..7
    localparam int obj_bank_lsb = 7;
    localparam int obj_bank_w = 7;

    // object code that lets the road through
    localparam logic [1:0] road_grp = 2'b10;
    localparam logic [3:0] road_col = 4'b0101;

endpackage

`default_nettype wire

/* design/layer_select.sv */
// layer priority mux building the registered palette address
`timescale 1ns/1ps
`default_nettype none

module layer_select (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    input  logic [layer_pkg::tmap_w-1:0] tmap_addr,
    input  logic [layer_pkg::obj_w-1:0]  obj_pxl,
    input  logic [layer_pkg::road_w-1:0] rd_pxl,
    input  logic [4:3]                   rc,
    input  logic                         sa,
    input  logic                         sb,
    input  logic                         fix,
    output logic [pal_pkg::pal_aw-1:0]   pal_addr
);
    import layer_pkg::*;
    import pal_pkg::*;

    // object pixel from the previous pixel step
    logic [obj_w-1:0]     objl;
    logic [obj_col_w-1:0] objl_col;
    logic [1:0]           objl_grp;
    logic                 road_sel;
    logic                 tile_sel;
    logic [pal_aw-1:0]    road_addr;
    logic [pal_aw-1:0]    tile_addr;
    logic [pal_aw-1:0]    obj_addr;
    logic [pal_aw-1:0]    pre_addr;

    assign objl_col = objl[obj_col_w-1:0];
    assign objl_grp = objl[obj_grp_lsb +: 2];

    // road shows through a transparent object
    // rc[3] low or no tile layer active lets it in
    // group 10 colour 0101 is a see-through object code
    // fix always wins over the road
    // rc[4] only steers the road colour mux, absent here
    assign road_sel = !fix && (
        (objl_col == '0 && (!rc[3] || (!sa && !sb))) ||
        (objl_grp == road_grp && objl_col == road_col));

    // any tile layer on top
    assign tile_sel = sa | sb | fix;

    // road bit 7 mirrored into the three middle bits
    assign road_addr = {road_bank, {3{rd_pxl[road_w-1]}}, rd_pxl[road_w-2:0]};
    assign tile_addr = {1'b0, tmap_addr};
    // shadow and priority bits 6..4 skipped
    assign obj_addr  = {1'b1, obj_pxl[obj_bank_lsb +: obj_bank_w],
                        obj_pxl[obj_col_w-1:0]};

    always_comb begin
        if (road_sel) begin
            pre_addr = road_addr;
        end else if (tile_sel) begin
            pre_addr = tile_addr;
        end else begin
            pre_addr = obj_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            objl     <= '0;
            pal_addr <= '0;
        end else if (pxl_cen) begin
            objl     <= obj_pxl;
            pal_addr <= pre_addr;
        end
    end

endmodule

`default_nettype wire

/* design/palette_ram.sv */
// palette memory with cpu byte-lane port and video read port
`timescale 1ns/1ps
`default_nettype none

module palette_ram (
    input  logic                       clk,
    // cpu side
    input  logic [pal_pkg::pal_aw-1:0] cpu_addr,
    input  logic [pal_pkg::pal_dw-1:0] cpu_dout,
    input  logic [1:0]                 cpu_we,
    output logic [pal_pkg::pal_dw-1:0] cpu_din,
    // video side, read only
    input  logic [pal_pkg::pal_aw-1:0] vid_addr,
    output logic [pal_pkg::pal_dw-1:0] pal_q
);
    import pal_pkg::*;

    localparam int byte_w = pal_dw / 2;
    localparam int depth  = 1 << pal_aw;

    logic [pal_dw-1:0] mem [0:depth-1];

    // cpu writes per byte lane
    // lane 1 is the upper byte
    always_ff @(posedge clk) begin
        if (cpu_we[0]) begin
            mem[cpu_addr][byte_w-1:0] <= cpu_dout[byte_w-1:0];
        end
        if (cpu_we[1]) begin
            mem[cpu_addr][pal_dw-1:byte_w] <= cpu_dout[pal_dw-1:byte_w];
        end
    end

    // cpu readback, old data on the write clock
    always_ff @(posedge clk) begin
        cpu_din <= mem[cpu_addr];
    end

    // video read every clock
    // settles well before the next pixel step
    always_ff @(posedge clk) begin
        pal_q <= mem[vid_addr];
    end

endmodule

`default_nettype wire

/* design/shade_unit.sv */
// palette entry unpack to rgb channels with shadow dim and light
`timescale 1ns/1ps
`default_nettype none

module shade_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  logic [pal_pkg::pal_dw-1:0] pal_q,
    input  logic                       shadow,
    output logic [pal_pkg::rgb_w-1:0]  rgb_shaded
);
    import pal_pkg::*;

    localparam int nib_w = chan_w - 1;

    logic [chan_w-1:0] r_pal;
    logic [chan_w-1:0] g_pal;
    logic [chan_w-1:0] b_pal;
    logic [rgb_w-1:0]  rgb_nxt;

    // shadow darkening, a minus a quarter
    function automatic logic [chan_w-1:0] dim(input logic [chan_w-1:0] a);
        dim = a - (a >> 2);
    endfunction

    // shadow highlight, a plus a quarter, clipped at full scale
    function automatic logic [chan_w-1:0] light(input logic [chan_w-1:0] a);
        logic [chan_w:0] sum;
        sum = {1'b0, a} + {1'b0, a >> 2};
        light = sum[chan_w] ? '1 : sum[chan_w-1:0];
    endfunction

    // nibble on top, shared bit as lsb
    assign r_pal = {pal_q[red_nib_lsb +: nib_w], pal_q[red_ext_bit]};
    assign g_pal = {pal_q[grn_nib_lsb +: nib_w], pal_q[grn_ext_bit]};
    assign b_pal = {pal_q[blu_nib_lsb +: nib_w], pal_q[blu_ext_bit]};

    always_comb begin
        if (!shadow) begin
            // no shadow over this pixel
            rgb_nxt = {r_pal, g_pal, b_pal};
        end else if (pal_q[shade_bit]) begin
            rgb_nxt = {light(r_pal), light(g_pal), light(b_pal)};
        end else begin
            rgb_nxt = {dim(r_pal), dim(g_pal), dim(b_pal)};
        end
    end

    // shadow sampled on the same step as the entry
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_shaded <= '0;
        end else if (pxl_cen) begin
            rgb_shaded <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* design/blank_align.sv */
// blanking delay chains and colour blackout inside blanking
`timescale 1ns/1ps
`default_nettype none

module blank_align #(
    parameter int blank_dly = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  logic                      preLHBL,
    input  logic                      preLVBL,
    input  logic [pal_pkg::rgb_w-1:0] rgb_in,
    output logic                      LHBL,
    output logic                      LVBL,
    output logic [pal_pkg::rgb_w-1:0] rgb
);

    // bit 0 takes the live strobe, top bit drives the output
    logic [blank_dly-1:0] hb_sh;
    logic [blank_dly-1:0] vb_sh;
    // chain contents after the coming pixel step
    logic [blank_dly-1:0] hb_nxt;
    logic [blank_dly-1:0] vb_nxt;
    logic                 show;

    assign hb_nxt = (hb_sh << 1) | blank_dly'(preLHBL);
    assign vb_nxt = (vb_sh << 1) | blank_dly'(preLVBL);

    // gate with the strobes that leave together with this colour
    assign show = hb_nxt[blank_dly-1] & vb_nxt[blank_dly-1];

    // low means blanked, so reset starts blanked
    always_ff @(posedge clk) begin
        if (rst) begin
            hb_sh <= '0;
            vb_sh <= '0;
        end else if (pxl_cen) begin
            hb_sh <= hb_nxt;
            vb_sh <= vb_nxt;
        end
    end

    // black outside the active area
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            rgb <= show ? rgb_in : '0;
        end
    end

    assign LHBL = hb_sh[blank_dly-1];
    assign LVBL = vb_sh[blank_dly-1];

endmodule

`default_nettype wire

/* design/colmix_top.sv */
// colour mixer top: layer select, palette, shadow and blanking stages
`timescale 1ns/1ps
`default_nettype none

module colmix_top #(
    // pixel steps from prestrobe to strobe, matches colour path depth
    parameter int blank_dly = 3
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    // raw blanking from the timing generator
    input  logic                         preLHBL,
    input  logic                         preLVBL,
    // cpu palette access
    input  logic                         pal_cs,
    input  logic [pal_pkg::pal_aw-1:0]   cpu_addr,
    input  logic [pal_pkg::pal_dw-1:0]   cpu_dout,
    input  logic [1:0]                   dswn,
    output logic [pal_pkg::pal_dw-1:0]   cpu_din,
    // layer outputs
    input  logic [layer_pkg::tmap_w-1:0] tmap_addr,
    input  logic [layer_pkg::obj_w-1:0]  obj_pxl,
    input  logic [layer_pkg::road_w-1:0] rd_pxl,
    input  logic [4:3]                   rc,
    input  logic                         shadow,
    input  logic                         sa,
    input  logic                         sb,
    input  logic                         fix,
    // video out
    output logic [pal_pkg::chan_w-1:0]   red,
    output logic [pal_pkg::chan_w-1:0]   green,
    output logic [pal_pkg::chan_w-1:0]   blue,
    output logic                         LHBL,
    output logic                         LVBL
);
    import pal_pkg::*;

    logic [1:0]        cpu_we;
    logic [pal_aw-1:0] pal_addr;
    logic [pal_dw-1:0] pal_q;
    logic [rgb_w-1:0]  rgb_shaded;
    logic [rgb_w-1:0]  rgb;

    // active-low strobes qualified by the chip select
    assign cpu_we = ~dswn & {2{pal_cs}};

    // step k, palette address
    layer_select u_sel (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .tmap_addr (tmap_addr),
        .obj_pxl   (obj_pxl),
        .rd_pxl    (rd_pxl),
        .rc        (rc),
        .sa        (sa),
        .sb        (sb),
        .fix       (fix),
        .pal_addr  (pal_addr)
    );

    // one clock after the address
    palette_ram u_pal (
        .clk      (clk),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_we   (cpu_we),
        .cpu_din  (cpu_din),
        .vid_addr (pal_addr),
        .pal_q    (pal_q)
    );

    // step k+1, shaded colour
    shade_unit u_shade (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .pal_q      (pal_q),
        .shadow     (shadow),
        .rgb_shaded (rgb_shaded)
    );

    // step k+2, blanked colour and aligned strobes
    blank_align #(
        .blank_dly (blank_dly)
    ) u_blank (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .preLHBL (preLHBL),
        .preLVBL (preLVBL),
        .rgb_in  (rgb_shaded),
        .LHBL    (LHBL),
        .LVBL    (LVBL),
        .rgb     (rgb)
    );

    // red in the top bits
    assign red   = rgb[2*chan_w +: chan_w];
    assign green = rgb[chan_w +: chan_w];
    assign blue  = rgb[0 +: chan_w];

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
// testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period high, half low
    always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

/* bench/colmix_tb.sv */
// colour mixer testbench with stimulus, palette model, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module colmix_tb;

    localparam int clk_period = 20;
    // full palette fill, one word per clock
    localparam int n_fill = 4096;
    // random cpu accesses, each one followed by a readback
    localparam int n_cpu = 400;
    // video pixel steps, two clocks each
    localparam int n_steps = 800;
    // whole run in clocks, then doubled
    localparam int timeout_ns = 2 * clk_period * (n_fill + 2 * n_cpu + 2 * n_steps + 100);

    logic        clk;
    logic        rst;
    logic        pxl_cen = 1'b0;
    logic        preLHBL;
    logic        preLVBL;
    logic        pal_cs;
    logic [11:0] cpu_addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dswn;
    logic [15:0] cpu_din;
    logic [10:0] tmap_addr;
    logic [13:0] obj_pxl;
    logic [7:0]  rd_pxl;
    logic [4:3]  rc;
    logic        shadow;
    logic        sa;
    logic        sb;
    logic        fix;
    logic [4:0]  red;
    logic [4:0]  green;
    logic [4:0]  blue;
    logic        LHBL;
    logic        LVBL;

    integer seed;
    int     val_errs = 0;
    int     other_errs = 0;
    logic   din_chk;

    // palette as the cpu wrote it
    logic [15:0] mem_model [0:4095];
    logic [15:0] exp_din;
    // expected pipeline, one register per pixel step
    logic [13:0] obj_prev;
    logic [11:0] exp_addr;
    logic [14:0] exp_shaded;
    logic [14:0] exp_rgb;
    logic [2:0]  hb_hist;
    logic [2:0]  vb_hist;

    tb_clock #(.period_ns(clk_period)) u_clk (.clk(clk));

    colmix_top #(.blank_dly(3)) DUT (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .preLHBL(preLHBL), .preLVBL(preLVBL),
        .pal_cs(pal_cs), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .dswn(dswn),
        .cpu_din(cpu_din),
        .tmap_addr(tmap_addr), .obj_pxl(obj_pxl), .rd_pxl(rd_pxl), .rc(rc),
        .shadow(shadow), .sa(sa), .sb(sb), .fix(fix),
        .red(red), .green(green), .blue(blue), .LHBL(LHBL), .LVBL(LVBL)
    );

    // pixel enable on every other clock
    always @(posedge clk) pxl_cen <= ~pxl_cen;

    // road first, then tiles, then objects
    function automatic logic [11:0] pick_addr(input logic [13:0] prev, input logic [10:0] tm,
                                              input logic [13:0] obj, input logic [7:0] rd,
                                              input logic [4:3] rcv, input logic a,
                                              input logic b, input logic f);
        logic clear_obj;
        logic see_thru;
        clear_obj = (prev[3:0] == 4'h0) && (!rcv[3] || (!a && !b));
        see_thru  = (prev[11:10] == 2'b10) && (prev[3:0] == 4'b0101);
        if (!f && (clear_obj || see_thru)) begin
            pick_addr = {2'b01, rd[7], rd[7], rd[7], rd[6:0]};
        end else if (a || b || f) begin
            pick_addr = {1'b0, tm};
        end else begin
            pick_addr = {1'b1, obj[13:7], obj[3:0]};
        end
    endfunction

    // one channel under the shadow rule
    function automatic logic [4:0] shade_chan(input logic [4:0] v, input logic on,
                                              input logic up);
        logic [5:0] quarter;
        logic [5:0] sum;
        quarter = {3'b000, v[4:2]};
        if (!on) begin
            shade_chan = v;
        end else if (up) begin
            sum = {1'b0, v} + quarter;
            shade_chan = (sum > 6'd31) ? 5'd31 : sum[4:0];
        end else begin
            sum = {1'b0, v} - quarter;
            shade_chan = sum[4:0];
        end
    endfunction

    // entry to packed rgb, shared bits 12..14 as lsbs
    function automatic logic [14:0] expect_colour(input logic [15:0] e, input logic shd);
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
        r = {e[3:0], e[12]};
        g = {e[7:4], e[13]};
        b = {e[11:8], e[14]};
        expect_colour = {shade_chan(r, shd, e[15]), shade_chan(g, shd, e[15]),
                         shade_chan(b, shd, e[15])};
    endfunction

    // palette model, no reset like the real ram
    always @(posedge clk) begin
        exp_din <= mem_model[cpu_addr];
        if (pal_cs && !dswn[0]) begin
            mem_model[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        if (pal_cs && !dswn[1]) begin
            mem_model[cpu_addr][15:8] <= cpu_dout[15:8];
        end
    end

    // expected video pipeline
    always @(posedge clk) begin
        if (rst) begin
            obj_prev   <= '0;
            exp_addr   <= '0;
            exp_shaded <= '0;
            exp_rgb    <= '0;
            hb_hist    <= '0;
            vb_hist    <= '0;
        end else if (pxl_cen) begin
            obj_prev   <= obj_pxl;
            exp_addr   <= pick_addr(obj_prev, tmap_addr, obj_pxl, rd_pxl, rc, sa, sb, fix);
            exp_shaded <= expect_colour(mem_model[exp_addr], shadow);
            hb_hist    <= {hb_hist[1:0], preLHBL};
            vb_hist    <= {vb_hist[1:0], preLVBL};
            // gated by the strobes leaving with it
            exp_rgb    <= (hb_hist[1] && vb_hist[1]) ? exp_shaded : '0;
        end
    end

    // checks on the falling edge, all values settled
    a_din: assert property (@(negedge clk) disable iff (rst) din_chk |-> cpu_din === exp_din)
        else begin
            val_errs = val_errs + 1;
            $display("mismatch cpu_din: got %h expected %h", cpu_din, exp_din);
        end
    a_red: assert property (@(negedge clk) disable iff (rst) red === exp_rgb[14:10])
        else begin
            val_errs = val_errs + 1;
            $display("mismatch red: got %h expected %h", red, exp_rgb[14:10]);
        end
    a_green: assert property (@(negedge clk) disable iff (rst) green === exp_rgb[9:5])
        else begin
            val_errs = val_errs + 1;
            $display("mismatch green: got %h expected %h", green, exp_rgb[9:5]);
        end
    a_blue: assert property (@(negedge clk) disable iff (rst) blue === exp_rgb[4:0])
        else begin
            val_errs = val_errs + 1;
            $display("mismatch blue: got %h expected %h", blue, exp_rgb[4:0]);
        end
    a_lhbl: assert property (@(negedge clk) disable iff (rst) LHBL === hb_hist[2])
        else begin
            val_errs = val_errs + 1;
            $display("mismatch LHBL: got %h expected %h", LHBL, hb_hist[2]);
        end
    a_lvbl: assert property (@(negedge clk) disable iff (rst) LVBL === vb_hist[2])
        else begin
            val_errs = val_errs + 1;
            $display("mismatch LVBL: got %h expected %h", LVBL, vb_hist[2]);
        end
    a_black: assert property (@(negedge clk) disable iff (rst)
                              (!LHBL || !LVBL) |-> ({red, green, blue} == 15'd0))
        else begin
            other_errs = other_errs + 1;
            $display("colour is not black while blanked");
        end
    a_reset: assert property (@(negedge clk) disable iff (rst)
                              $fell(rst) |-> (!LHBL && !LVBL && {red, green, blue} == 15'd0))
        else begin
            other_errs = other_errs + 1;
            $display("outputs are not blanked and black right after reset");
        end

    // one cpu bus cycle
    task automatic cpu_access(input logic [11:0] addr, input logic [15:0] data,
                              input logic cs, input logic [1:0] strobes);
        @(posedge clk);
        pal_cs   <= cs;
        cpu_addr <= addr;
        cpu_dout <= data;
        dswn     <= strobes;
    endtask

    // new layer values right after a pixel step
    task automatic pixel_step(input logic [2:0] mode, input logic hb, input logic vb);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [13:0] obj;
        logic [10:0] tm;
        logic        a;
        logic        b;
        logic        f;
        logic        shd;
        r1  = $random(seed);
        r2  = $random(seed);
        obj = r1[24:11];
        tm  = r1[10:0];
        a   = r2[10];
        b   = r2[11];
        f   = r2[12];
        shd = r2[13];
        case (mode)
            // tile layer, plain colour
            3'd0: begin
                f   = 1'b1;
                shd = 1'b0;
            end
            // object with a visible colour
            3'd1, 3'd5: begin
                a = 1'b0;
                b = 1'b0;
                f = 1'b0;
                if (obj[3:0] == 4'h0 || obj[3:0] == 4'b0101) begin
                    obj[3:0] = 4'b0110;
                end
                if (mode == 3'd5) begin
                    shd = 1'b1;
                end
            end
            // transparent object
            3'd2: begin
                obj[3:0] = 4'h0;
                f = 1'b0;
            end
            // see-through object code
            3'd3: begin
                obj[11:10] = 2'b10;
                obj[3:0]   = 4'b0101;
                f = 1'b0;
            end
            // saturating entries under shadow
            3'd4: begin
                f   = 1'b1;
                tm  = {10'd0, r1[0]};
                shd = 1'b1;
            end
            default: begin
            end
        endcase
        @(posedge clk);
        while (!pxl_cen) @(posedge clk);
        preLHBL   <= hb;
        preLVBL   <= vb;
        tmap_addr <= tm;
        obj_pxl   <= obj;
        rd_pxl    <= r2[7:0];
        rc        <= r2[9:8];
        sa        <= a;
        sb        <= b;
        fix       <= f;
        shadow    <= shd;
    endtask

    // watchdog
    initial begin
        #(timeout_ns);
        other_errs = other_errs + 1;
        $display("run did not finish within %0d ns", timeout_ns);
        $display("errors: value %0d, other %0d", val_errs, other_errs);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [2:0]  mode;
        seed = 52;
        rst = 1'b1;
        din_chk = 1'b0;
        preLHBL = 1'b0;
        preLVBL = 1'b0;
        pal_cs = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        dswn = 2'b11;
        tmap_addr = '0;
        obj_pxl = '0;
        rd_pxl = '0;
        rc = '0;
        shadow = 1'b0;
        sa = 1'b0;
        sb = 1'b0;
        fix = 1'b0;
        mode = 3'd0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // every word gets a value tied to its full address
        for (int i = 0; i < n_fill; i++) begin
            cpu_access(i[11:0], {i[3:0], i[11:0]} ^ 16'h5a3c, 1'b1, 2'b00);
        end
        cpu_access(12'h000, 16'h0000, 1'b0, 2'b11);
        repeat (2) @(posedge clk);
        din_chk <= 1'b1;

        // byte-lane writes, each read back on the next cycle
        for (int i = 0; i < n_cpu; i++) begin
            r = $random(seed);
            cpu_access(r[4] ? r[27:16] : {6'd0, r[21:16]}, r[15:0], r[0] | r[1], r[3:2]);
            cpu_access(r[4] ? r[27:16] : {6'd0, r[21:16]}, 16'h0000, 1'b0, 2'b11);
        end

        // full scale entries, light then dim
        cpu_access(12'h000, 16'hffff, 1'b1, 2'b00);
        cpu_access(12'h001, 16'h7fff, 1'b1, 2'b00);
        cpu_access(12'h001, 16'h0000, 1'b0, 2'b11);

        // video, layer mode changes every four steps
        for (int i = 0; i < n_steps; i++) begin
            if (i % 4 == 0) begin
                r = $random(seed);
                mode = r[2:0];
            end
            pixel_step(mode, (i % 50) >= 5, (i % 300) >= 3);
        end
        // let the pipeline drain
        for (int i = 0; i < 8; i++) begin
            pixel_step(3'd0, 1'b1, 1'b1);
        end
        repeat (4) @(posedge clk);

        $display("errors: value %0d, other %0d", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* colmix_top.f */
design/pal_pkg.sv
design/layer_pkg.sv
design/layer_select.sv
design/palette_ram.sv
design/shade_unit.sv
design/blank_align.sv
design/colmix_top.sv
bench/tb_clock.sv
bench/colmix_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the colour mixer testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module colmix_tb \
    -f colmix_top.f -o colmix_sim \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/colmix_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1
